/* common/sdram_consts.svh */
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// delay counter loads, the real wait is one cycle longer
`define SDRAM_DELAY_W 3
`define SDRAM_T_CAS 3'd2 // 3 cycles
`define SDRAM_T_PRE 3'd2 // 3 cycles
`define SDRAM_T_ACT 3'd2 // 3 cycles
`define SDRAM_T_REF 3'd6 // 7 cycles

// refresh period, counter wraps after this value
`define SDRAM_REFRESH_W 10
`define SDRAM_REFRESH_INTERVAL 10'd751

// user word and pin widths
`define SDRAM_ADDR_W 23
`define SDRAM_DATA_W 32
`define SDRAM_ROW_W 13
`define SDRAM_BANK_W 2
`define SDRAM_COL_W 8
`define SDRAM_NUM_BANKS 4

// mode register value driven on the address pins at init
//   [12:10] reserved
//   [9]     burst access on writes
//   [8:7]   standard operation
//   [6:4]   CAS latency 2
//   [3]     sequential burst
//   [2:0]   burst length 4
`define SDRAM_MODE_WORD 13'b000_0_00_010_0_010

`endif

/* common/sdram_cmd_pkg.sv */
package sdram_cmd_pkg;

    // bit order is {cs, ras, cas, we}, all pins active low
    typedef enum logic [3:0] {
        cmd_unselected = 4'b1000, // chip deselected
        cmd_nop        = 4'b0111,
        cmd_active     = 4'b0011, // open row on ba
        cmd_read       = 4'b0101,
        cmd_write      = 4'b0100,
        cmd_precharge  = 4'b0010, // a10 high closes all banks
        cmd_refresh    = 4'b0001  // auto refresh, all banks idle
    } sdram_cmd_t;

endpackage

/* common/sdram_ctrl_pkg.sv */
`include "sdram_consts.svh"

package sdram_ctrl_pkg;

    // user address split as row | bank | col
    typedef struct packed {
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_COL_W-1:0]  col;
    } sdram_addr_fields_t;

    // same 23-bit word, seen flat or by field
    typedef union packed {
        logic [`SDRAM_ADDR_W-1:0] flat;
        sdram_addr_fields_t       fields;
    } sdram_addr_t;

    // command sequencer states
    typedef enum logic [3:0] {
        seq_init,
        seq_wait_delay,  // counts down delay, then goes to saved state
        seq_idle,
        seq_refresh,
        seq_activate,
        seq_read,
        seq_read_result,
        seq_write,
        seq_precharge
    } seq_state_t;

endpackage

/* verilog/request_slot.sv */
`include "sdram_consts.svh"

module request_slot (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic                        rw,
    input  sdram_ctrl_pkg::sdram_addr_t addr_in,
    input  logic [`SDRAM_DATA_W-1:0]    data_in,
    input  logic                        take,     // sequencer has copied the request
    output logic                        busy,
    output logic                        req_rw,
    output sdram_ctrl_pkg::sdram_addr_t req_addr,
    output logic [`SDRAM_DATA_W-1:0]    req_data
);

    logic accept;

    // strobes while full are dropped
    assign accept = in_valid && !busy;

    // busy stays up from reset until the sequencer leaves init
    always_ff @(posedge clk) begin
        if (rst)
            busy <= 1'b1;
        else if (take)
            busy <= 1'b0;
        else if (accept)
            busy <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_rw        <= rw;
            req_addr.flat <= addr_in.flat;
            req_data      <= data_in;
        end
    end

endmodule

/* verilog/bank_tracker.sv */
`include "sdram_consts.svh"

module bank_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  sdram_ctrl_pkg::sdram_addr_t lookup_addr,
    input  logic                        row_activate,
    input  sdram_ctrl_pkg::sdram_addr_t active_addr,  // bank and row being opened
    input  logic                        bank_close,
    input  logic [`SDRAM_BANK_W-1:0]    close_bank,
    input  logic                        close_all,
    output logic                        row_open,
    output logic                        row_hit
);

    logic [`SDRAM_NUM_BANKS-1:0] open_q;
    logic [`SDRAM_ROW_W-1:0]     row_q [`SDRAM_NUM_BANKS];
    logic [`SDRAM_BANK_W-1:0]    lookup_bank;

    assign lookup_bank = lookup_addr.fields.bank;
    assign row_open    = open_q[lookup_bank];
    assign row_hit     = row_open && (row_q[lookup_bank] == lookup_addr.fields.row);

    always_ff @(posedge clk) begin
        if (rst || close_all) begin
            open_q <= '0;
        end else begin
            if (bank_close)
                open_q[close_bank] <= 1'b0;
            if (row_activate)
                open_q[active_addr.fields.bank] <= 1'b1;
        end
    end

    // row value only matters while its open flag is set
    always_ff @(posedge clk) begin
        if (row_activate)
            row_q[active_addr.fields.bank] <= active_addr.fields.row;
    end

endmodule

/* verilog/refresh_timer.sv */
`include "sdram_consts.svh"

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_due
);

    logic [`SDRAM_REFRESH_W-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= `SDRAM_REFRESH_W'd1;
            refresh_due <= 1'b0;
        end else if (count_q == `SDRAM_REFRESH_INTERVAL) begin
            count_q     <= '0;
            refresh_due <= 1'b1; // sticky until the sequencer takes it
        end else begin
            count_q <= count_q + 1'b1;
            if (refresh_ack)
                refresh_due <= 1'b0;
        end
    end

endmodule

/* sequencer/sdram_sequencer.sv */
`include "sdram_consts.svh"

module sdram_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        busy,        // request waiting in slot
    input  logic                        req_rw,
    input  sdram_ctrl_pkg::sdram_addr_t req_addr,
    input  logic [`SDRAM_DATA_W-1:0]    req_data,
    input  logic                        row_open,
    input  logic                        row_hit,
    input  logic                        refresh_due,
    output logic                        take,
    output logic                        refresh_ack,
    output logic                        row_activate,
    output sdram_ctrl_pkg::sdram_addr_t active_addr,
    output logic                        bank_close,
    output logic                        close_all,
    output logic [`SDRAM_BANK_W-1:0]    close_bank,
    output logic                        cle,
    output logic                        cs,
    output logic                        ras,
    output logic                        cas,
    output logic                        we,
    output logic [`SDRAM_BANK_W-1:0]    ba,
    output logic [`SDRAM_ROW_W-1:0]     a,
    input  logic [`SDRAM_DATA_W-1:0]    dqi,
    output logic [`SDRAM_DATA_W-1:0]    dqo,
    output logic [`SDRAM_DATA_W-1:0]    rd_data,
    output logic                        rd_valid
);

    sdram_ctrl_pkg::seq_state_t  state_q, state_d;
    sdram_ctrl_pkg::seq_state_t  next_q, next_d;   // where wait_delay goes
    logic [`SDRAM_DELAY_W-1:0]   delay_q, delay_d;

    // request in flight
    sdram_ctrl_pkg::sdram_addr_t work_addr_q, work_addr_d;
    logic                        work_rw_q, work_rw_d;
    logic [`SDRAM_DATA_W-1:0]    work_data_q, work_data_d;

    logic                        pre_all_q, pre_all_d;
    logic [`SDRAM_BANK_W-1:0]    pre_bank_q, pre_bank_d;

    // next values for the pin registers
    sdram_cmd_pkg::sdram_cmd_t   cmd_q, cmd_d;
    logic                        cle_q, cle_d;
    logic [`SDRAM_BANK_W-1:0]    ba_q, ba_d;
    logic [`SDRAM_ROW_W-1:0]     a_q, a_d;
    logic [`SDRAM_DATA_W-1:0]    dqo_q, dqo_d;

    logic [`SDRAM_DATA_W-1:0]    rd_data_q;
    logic                        rd_valid_q;

    // init also clears the busy level left by reset
    assign take = (state_q == sdram_ctrl_pkg::seq_init) ||
                  (state_q == sdram_ctrl_pkg::seq_idle && !refresh_due && busy);
    assign refresh_ack = (state_q == sdram_ctrl_pkg::seq_idle) && refresh_due;

    assign row_activate = state_q == sdram_ctrl_pkg::seq_activate;
    assign active_addr  = work_addr_q;
    assign bank_close   = (state_q == sdram_ctrl_pkg::seq_precharge) && !pre_all_q;
    assign close_all    = (state_q == sdram_ctrl_pkg::seq_precharge) && pre_all_q;
    assign close_bank   = pre_bank_q;

    assign {cs, ras, cas, we} = cmd_q;
    assign cle      = cle_q;
    assign ba       = ba_q;
    assign a        = a_q;
    assign dqo      = dqo_q;
    assign rd_data  = rd_data_q;
    assign rd_valid = rd_valid_q;

    always_comb begin
        state_d     = state_q;
        next_d      = next_q;
        delay_d     = delay_q;
        work_addr_d = work_addr_q;
        work_rw_d   = work_rw_q;
        work_data_d = work_data_q;
        pre_all_d   = pre_all_q;
        pre_bank_d  = pre_bank_q;
        cmd_d       = sdram_cmd_pkg::cmd_nop;
        cle_d       = cle_q;
        ba_d        = '0;
        a_d         = '0;
        dqo_d       = '0; // bus only carries data during a write

        case (state_q)
            sdram_ctrl_pkg::seq_init: begin
                cle_d   = 1'b1;
                a_d     = `SDRAM_MODE_WORD;
                delay_d = '0;
                next_d  = sdram_ctrl_pkg::seq_idle;
                state_d = sdram_ctrl_pkg::seq_wait_delay;
            end
            sdram_ctrl_pkg::seq_wait_delay: begin
                delay_d = delay_q - 1'b1;
                if (delay_q == '0)
                    state_d = next_q;
            end
            sdram_ctrl_pkg::seq_idle: begin
                if (refresh_due) begin // refresh beats a waiting request
                    pre_all_d = 1'b1;
                    next_d    = sdram_ctrl_pkg::seq_refresh;
                    state_d   = sdram_ctrl_pkg::seq_precharge;
                end else if (busy) begin
                    work_addr_d = req_addr;
                    work_rw_d   = req_rw;
                    work_data_d = req_data;
                    if (row_hit) begin
                        state_d = req_rw ? sdram_ctrl_pkg::seq_write
                                         : sdram_ctrl_pkg::seq_read;
                    end else if (row_open) begin
                        // wrong row open in this bank
                        pre_all_d  = 1'b0;
                        pre_bank_d = req_addr.fields.bank;
                        next_d     = sdram_ctrl_pkg::seq_activate;
                        state_d    = sdram_ctrl_pkg::seq_precharge;
                    end else begin
                        state_d = sdram_ctrl_pkg::seq_activate;
                    end
                end
            end
            sdram_ctrl_pkg::seq_refresh: begin
                cmd_d   = sdram_cmd_pkg::cmd_refresh;
                delay_d = `SDRAM_T_REF;
                next_d  = sdram_ctrl_pkg::seq_idle;
                state_d = sdram_ctrl_pkg::seq_wait_delay;
            end
            sdram_ctrl_pkg::seq_activate: begin
                cmd_d   = sdram_cmd_pkg::cmd_active;
                a_d     = work_addr_q.fields.row;
                ba_d    = work_addr_q.fields.bank;
                delay_d = `SDRAM_T_ACT;
                next_d  = work_rw_q ? sdram_ctrl_pkg::seq_write : sdram_ctrl_pkg::seq_read;
                state_d = sdram_ctrl_pkg::seq_wait_delay;
            end
            sdram_ctrl_pkg::seq_read: begin
                cmd_d   = sdram_cmd_pkg::cmd_read;
                a_d     = {2'b00, 1'b0, work_addr_q.fields.col, 2'b00}; // a10 low, no auto precharge
                ba_d    = work_addr_q.fields.bank;
                delay_d = `SDRAM_T_CAS;
                next_d  = sdram_ctrl_pkg::seq_read_result;
                state_d = sdram_ctrl_pkg::seq_wait_delay;
            end
            sdram_ctrl_pkg::seq_read_result: begin
                state_d = sdram_ctrl_pkg::seq_idle;
            end
            sdram_ctrl_pkg::seq_write: begin
                cmd_d   = sdram_cmd_pkg::cmd_write;
                a_d     = {2'b00, 1'b0, work_addr_q.fields.col, 2'b00};
                ba_d    = work_addr_q.fields.bank;
                dqo_d   = work_data_q;
                state_d = sdram_ctrl_pkg::seq_idle;
            end
            sdram_ctrl_pkg::seq_precharge: begin
                cmd_d     = sdram_cmd_pkg::cmd_precharge;
                a_d[10]   = pre_all_q;
                ba_d      = pre_bank_q;
                delay_d   = `SDRAM_T_PRE;
                state_d   = sdram_ctrl_pkg::seq_wait_delay;
            end
            default: begin
                cmd_d   = sdram_cmd_pkg::cmd_unselected;
                state_d = sdram_ctrl_pkg::seq_init;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= sdram_ctrl_pkg::seq_init;
            cmd_q      <= sdram_cmd_pkg::cmd_nop;
            cle_q      <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            cmd_q      <= cmd_d;
            cle_q      <= cle_d;
            rd_valid_q <= state_q == sdram_ctrl_pkg::seq_read_result;
        end
    end

    always_ff @(posedge clk) begin
        next_q      <= next_d;
        delay_q     <= delay_d;
        work_addr_q <= work_addr_d;
        work_rw_q   <= work_rw_d;
        work_data_q <= work_data_d;
        pre_all_q   <= pre_all_d;
        pre_bank_q  <= pre_bank_d;
        ba_q        <= ba_d;
        a_q         <= a_d;
        dqo_q       <= dqo_d;
        if (state_q == sdram_ctrl_pkg::seq_read_result)
            rd_data_q <= dqi; // 3 cycles after the read command
    end

endmodule

/* verilog/sdram_controller.sv */
`include "sdram_consts.svh"

module sdram_controller (
    input  logic                        clk,
    input  logic                        rst,
    input  sdram_ctrl_pkg::sdram_addr_t user_addr,
    input  logic                        rw,        // 1 = write
    input  logic                        in_valid,
    input  logic [`SDRAM_DATA_W-1:0]    data_in,
    output logic [`SDRAM_DATA_W-1:0]    data_out,
    output logic                        busy,
    output logic                        out_valid,
    output logic                        sdram_cle,
    output logic                        sdram_cs,
    output logic                        sdram_ras,
    output logic                        sdram_cas,
    output logic                        sdram_we,
    output logic [`SDRAM_BANK_W-1:0]    sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]     sdram_a,
    input  logic [`SDRAM_DATA_W-1:0]    sdram_dqi,
    output logic [`SDRAM_DATA_W-1:0]    sdram_dqo
);

    logic                        take;
    logic                        req_rw;
    sdram_ctrl_pkg::sdram_addr_t req_addr;
    logic [`SDRAM_DATA_W-1:0]    req_data;

    logic                        row_open;
    logic                        row_hit;
    logic                        row_activate;
    sdram_ctrl_pkg::sdram_addr_t active_addr;
    logic                        bank_close;
    logic [`SDRAM_BANK_W-1:0]    close_bank;
    logic                        close_all;

    logic refresh_due;
    logic refresh_ack;

    request_slot i_slot (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .rw       (rw),
        .addr_in  (user_addr),
        .data_in  (data_in),
        .take     (take),
        .busy     (busy),
        .req_rw   (req_rw),
        .req_addr (req_addr),
        .req_data (req_data)
    );

    // looks up the waiting request, not the one in flight
    bank_tracker i_tracker (
        .clk          (clk),
        .rst          (rst),
        .lookup_addr  (req_addr),
        .row_activate (row_activate),
        .active_addr  (active_addr),
        .bank_close   (bank_close),
        .close_bank   (close_bank),
        .close_all    (close_all),
        .row_open     (row_open),
        .row_hit      (row_hit)
    );

    refresh_timer i_refresh (
        .clk         (clk),
        .rst         (rst),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_sequencer i_seq (
        .clk          (clk),
        .rst          (rst),
        .busy         (busy),
        .req_rw       (req_rw),
        .req_addr     (req_addr),
        .req_data     (req_data),
        .row_open     (row_open),
        .row_hit      (row_hit),
        .refresh_due  (refresh_due),
        .take         (take),
        .refresh_ack  (refresh_ack),
        .row_activate (row_activate),
        .active_addr  (active_addr),
        .bank_close   (bank_close),
        .close_all    (close_all),
        .close_bank   (close_bank),
        .cle          (sdram_cle),
        .cs           (sdram_cs),
        .ras          (sdram_ras),
        .cas          (sdram_cas),
        .we           (sdram_we),
        .ba           (sdram_ba),
        .a            (sdram_a),
        .dqi          (sdram_dqi),
        .dqo          (sdram_dqo),
        .rd_data      (data_out),
        .rd_valid     (out_valid)
    );

endmodule

/* dv/sdram_model.sv */
`include "sdram_consts.svh"

module sdram_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cs,
    input  logic                     ras,
    input  logic                     cas,
    input  logic                     we,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_DATA_W-1:0] dqo,
    output logic [`SDRAM_DATA_W-1:0] dqi,
    output logic                     proto_err
);
    timeunit 1ns;
    timeprecision 1ps;

    // worst request that can hold off a due refresh
    localparam int MAX_REF_GAP   = `SDRAM_REFRESH_INTERVAL + 16;
    localparam int MAX_FIRST_REF = MAX_REF_GAP + 8; // timer starts at reset, not at a refresh

    logic [`SDRAM_DATA_W-1:0]    mem [int]; // sparse, keyed as {row, bank, col}
    logic [`SDRAM_NUM_BANKS-1:0] open_q;
    logic [`SDRAM_ROW_W-1:0]     row_q [`SDRAM_NUM_BANKS];
    logic [1:0]                  rd_wait;
    logic [`SDRAM_DATA_W-1:0]    rd_word;
    logic                        ref_seen;
    int                          ref_gap;
    int                          key;

    assign key = int'({row_q[ba], ba, a[9:2]}); // column sits on a[9:2]

    task automatic protocol_error(input string what);
        $display("sdram model: %s", what);
        proto_err <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            open_q    <= '0;
            rd_wait   <= '0;
            dqi       <= '0;
            ref_seen  <= 1'b0;
            ref_gap   <= 0;
            proto_err <= 1'b0;
        end else begin
            ref_gap <= ref_gap + 1;
            if (ref_gap > (ref_seen ? MAX_REF_GAP : MAX_FIRST_REF))
                protocol_error($sformatf("no refresh for %0d cycles", ref_gap));
            if (!cs && {cs, ras, cas, we} != sdram_cmd_pkg::cmd_nop)
                dqi <= '0; // any new command ends read data
            if (rd_wait == 2'd1)
                dqi <= rd_word;
            if (rd_wait != '0)
                rd_wait <= rd_wait - 1'b1;
            case ({cs, ras, cas, we})
                sdram_cmd_pkg::cmd_active: begin
                    if (open_q[ba])
                        protocol_error($sformatf("activate to bank %0d with a row open", ba));
                    open_q[ba] <= 1'b1;
                    row_q[ba]  <= a;
                end
                sdram_cmd_pkg::cmd_read: begin
                    if (!open_q[ba])
                        protocol_error($sformatf("read from closed bank %0d", ba));
                    rd_word <= mem.exists(key) ? mem[key] : '0;
                    rd_wait <= 2'd2; // data out 3 cycles after the command
                end
                sdram_cmd_pkg::cmd_write: begin
                    if (!open_q[ba])
                        protocol_error($sformatf("write to closed bank %0d", ba));
                    mem[key] = dqo;
                end
                sdram_cmd_pkg::cmd_precharge: begin
                    if (a[10])
                        open_q <= '0;
                    else
                        open_q[ba] <= 1'b0;
                end
                sdram_cmd_pkg::cmd_refresh: begin
                    if (open_q != '0)
                        protocol_error("refresh while a bank is still open");
                    ref_seen <= 1'b1;
                    ref_gap  <= 0;
                end
                default: ;
            endcase
        end
    end

endmodule

/* dv/tb_sdram_controller.sv */
`include "sdram_consts.svh"

module tb_sdram_controller;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQ    = 400;
    localparam int REQ_CYCLES = 20; // conflict read plus slot turnaround and strobe gaps
    localparam int REF_CYCLES = 12; // precharge-all, refresh and its wait
    localparam int MAX_CYCLES = NUM_REQ * (REQ_CYCLES + REF_CYCLES) + 100;

    logic                        clk = 1'b0;
    logic                        rst;
    sdram_ctrl_pkg::sdram_addr_t user_addr;
    logic                        rw;
    logic                        in_valid;
    logic [`SDRAM_DATA_W-1:0]    data_in;
    logic [`SDRAM_DATA_W-1:0]    data_out;
    logic                        busy;
    logic                        out_valid;
    logic                        sdram_cle;
    logic                        sdram_cs;
    logic                        sdram_ras;
    logic                        sdram_cas;
    logic                        sdram_we;
    logic [`SDRAM_BANK_W-1:0]    sdram_ba;
    logic [`SDRAM_ROW_W-1:0]     sdram_a;
    logic [`SDRAM_DATA_W-1:0]    sdram_dqi;
    logic [`SDRAM_DATA_W-1:0]    sdram_dqo;
    logic                        proto_err;
    logic [3:0]                  pin_cmd; // {cs, ras, cas, we} as seen on the pins

    logic [`SDRAM_DATA_W-1:0] ref_mem [int];
    logic [`SDRAM_DATA_W-1:0] exp_q [$];   // read results still owed, oldest first
    logic [`SDRAM_ADDR_W:0]   pend_q [$];  // {rw, addr} not yet seen on the pins
    logic [`SDRAM_ROW_W-1:0]  open_row [`SDRAM_NUM_BANKS]; // last row activated per bank
    int                       n_accepted = 0;
    int                       cycles = 0;
    int                       since_rst = 0;

    sdram_controller i_dut (.*);

    sdram_model i_model (
        .clk (clk), .rst (rst), .cs (sdram_cs), .ras (sdram_ras), .cas (sdram_cas),
        .we (sdram_we), .ba (sdram_ba), .a (sdram_a), .dqo (sdram_dqo),
        .dqi (sdram_dqi), .proto_err (proto_err)
    );

    assign pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // pin fields of a read or write against the request it serves
    task automatic check_access(input logic [`SDRAM_ADDR_W:0] req);
        sdram_ctrl_pkg::sdram_addr_t addr;
        addr.flat = req[`SDRAM_ADDR_W-1:0];
        compare("sdram_we", 32'(sdram_we), 32'(!req[`SDRAM_ADDR_W])); // low for a write
        compare("sdram_ba", 32'(sdram_ba), 32'(addr.fields.bank));
        compare("sdram_a", 32'(sdram_a), 32'({addr.fields.col, 2'b00}));
        compare("open_row", 32'(open_row[sdram_ba]), 32'(addr.fields.row));
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    initial begin
        sdram_ctrl_pkg::sdram_addr_t addr;
        void'($urandom(33652));
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // strobes come whether or not busy is high
        while (n_accepted < NUM_REQ) begin
            @(posedge clk);
            addr.fields.row  = 13'($urandom_range(0, 2) * 32'h0a35); // few rows, so hits and conflicts
            addr.fields.bank = 2'($urandom_range(0, 3));
            addr.fields.col  = 8'($urandom_range(0, 7));
            in_valid  <= 1'($urandom_range(0, 1));
            rw        <= 1'($urandom_range(0, 1));
            user_addr <= addr;
            data_in   <= $urandom();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0 || pend_q.size() != 0 || busy)
            @(posedge clk);
        @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

    always @(negedge clk) begin
        if (rst) begin
            since_rst = 0;
            compare("busy", 32'(busy), 32'd1);
            compare("sdram_cle", 32'(sdram_cle), 32'd0);
            compare("sdram_cmd", 32'(pin_cmd), 32'(sdram_cmd_pkg::cmd_nop));
            compare("out_valid", 32'(out_valid), 32'd0);
        end else begin
            if (proto_err)
                stop_run("SDRAM model saw a protocol violation");
            if (since_rst == 0) begin
                compare("busy", 32'(busy), 32'd1);
                compare("sdram_cle", 32'(sdram_cle), 32'd0);
            end else begin
                compare("sdram_cle", 32'(sdram_cle), 32'd1); // cle never drops again
            end
            if (since_rst == 1) begin // init cycle on the pins
                compare("busy", 32'(busy), 32'd0);
                compare("sdram_a", 32'(sdram_a), 32'(`SDRAM_MODE_WORD));
            end
            since_rst++;
            if (in_valid && !busy) begin
                n_accepted++;
                pend_q.push_back({rw, user_addr.flat});
                if (rw)
                    ref_mem[int'(user_addr.flat)] = data_in;
                else if (ref_mem.exists(int'(user_addr.flat)))
                    exp_q.push_back(ref_mem[int'(user_addr.flat)]);
                else
                    exp_q.push_back('0); // unwritten word reads as zero
            end
            if (pin_cmd == sdram_cmd_pkg::cmd_active)
                open_row[sdram_ba] = sdram_a;
            if (pin_cmd == sdram_cmd_pkg::cmd_read || pin_cmd == sdram_cmd_pkg::cmd_write) begin
                if (pend_q.size() == 0)
                    stop_run("read or write on the pins with no request pending");
                else
                    check_access(pend_q.pop_front());
            end
            if (out_valid) begin
                if (exp_q.size() == 0)
                    stop_run("out_valid pulsed with no read pending");
                else
                    compare("data_out", data_out, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES)
            stop_run($sformatf("timeout after %0d cycles, %0d reads pending",
                               cycles, exp_q.size()));
    end

endmodule

/* list.f */
+incdir+common
common/sdram_cmd_pkg.sv
common/sdram_ctrl_pkg.sv
verilog/request_slot.sv
verilog/bank_tracker.sv
verilog/refresh_timer.sv
sequencer/sdram_sequencer.sv
verilog/sdram_controller.sv
dv/sdram_model.sv
dv/tb_sdram_controller.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module tb_sdram_controller &&
{ ./obj_dir/Vtb_sdram_controller > sim.log 2>&1 || true; } &&
grep -qx "TEST PASS" sim.log ||
{ echo "simulation failed, see sim.log"; exit 1; }
